/* Makefile */
# Verilator build and run of the prefetch controller testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_prefetch_ctrl
FILELIST  = tb.f

# Verilator default output directory
BUILD_DIR = obj_dir

.PHONY: sim clean

# Build, run, and pass only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "^TEST OK$$"; then \
	  exit 0; \
	else \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

/* logic/prefetch_addr_fsm.sv */
//////////////////////////////////////////////////////////////////////
// Prefetch request and address generation
// Gates fetch requests against FIFO capacity, replays an unaccepted
// branch target and advances the transaction address by one word
// on every accepted request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_addr_fsm (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                req_i,
  input  wire logic                branch_i,
  input  wire prefetch_pkg::addr_t branch_addr_i,
  input  wire prefetch_pkg::cnt_t  fifo_cnt_i,
  input  wire prefetch_pkg::cnt_t  outstanding_cnt_i,
  input  wire logic                trans_ready_i,
  output logic                     trans_valid_o,
  output prefetch_pkg::addr_t      trans_addr_o,
  output logic                     accepted_o
);

  // Only two states are needed, normal prefetch and waiting for the
  // bus to take a branch target that missed its own cycle
  typedef enum logic {
    state_idle,
    state_branch_wait
  } state_t;

  state_t              state_q;
  state_t              state_d;
  prefetch_pkg::addr_t trans_addr_q;
  prefetch_pkg::addr_t addr_incr;
  prefetch_pkg::addr_t branch_addr_aligned;
  prefetch_pkg::cnt_t  fifo_cnt_masked;
  // One bit wider than a count so that the sum cannot wrap
  logic [prefetch_pkg::CNT_W:0] slots_used;

  //////////////////////////////////////////////////////////////////////
  // Request gating
  //////////////////////////////////////////////////////////////////////

  // A branch flushes the FIFO in the same cycle, so its entries do
  // not take up space for the new target request
  assign fifo_cnt_masked = branch_i ? '0 : fifo_cnt_i;

  assign slots_used = {1'b0, fifo_cnt_masked} + {1'b0, outstanding_cnt_i};

  // Never request more than the FIFO can hold once every response lands
  assign trans_valid_o = req_i &&
                         (slots_used < (prefetch_pkg::CNT_W + 1)'(prefetch_pkg::DEPTH));

  assign accepted_o = trans_valid_o && trans_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Address selection and state machine
  //////////////////////////////////////////////////////////////////////

  // The prefetcher only ever issues word fetches
  assign branch_addr_aligned = {branch_addr_i[prefetch_pkg::ADDR_W-1:2], 2'b00};
  assign addr_incr = {trans_addr_q[prefetch_pkg::ADDR_W-1:2], 2'b00} + prefetch_pkg::ADDR_STEP;

  always_comb begin
    state_d = state_q;

    // A new branch always wins, even while an older target is pending
    if (branch_i) begin
      trans_addr_o = branch_addr_aligned;
    end else if (state_q == state_branch_wait) begin
      trans_addr_o = trans_addr_q;
    end else begin
      trans_addr_o = addr_incr;
    end

    case (state_q)
      state_idle: begin
        // Target not taken by the bus yet, keep replaying it
        if (branch_i && !accepted_o) begin
          state_d = state_branch_wait;
        end
      end
      state_branch_wait: begin
        // Target is out, sequential prefetch resumes from here
        if (accepted_o) begin
          state_d = state_idle;
        end
      end
      default: begin
        state_d = state_idle;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= state_idle;
      trans_addr_q <= '0;
    end else begin
      state_q <= state_d;
      // Under back-pressure with no branch the address simply holds
      if (branch_i || accepted_o) begin
        trans_addr_q <= trans_addr_o;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/prefetch_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Instruction prefetch controller
// Sits between the fetch stage and the bus adapter, issuing word
// requests, redirecting on branches and steering responses into
// the prefetch FIFO or straight to the fetch stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_ctrl (
  input  wire logic                clk,
  input  wire logic                rst_n,

  // Fetch stage side
  input  wire logic                req_i,
  input  wire logic                branch_i,
  input  wire prefetch_pkg::addr_t branch_addr_i,
  input  wire logic                fetch_ready_i,
  output logic                     fetch_valid_o,
  output logic                     busy_o,

  // Request channel to the bus adapter
  output logic                     trans_valid_o,
  output prefetch_pkg::addr_t      trans_addr_o,
  input  wire logic                trans_ready_i,

  // Response channel, always accepted
  input  wire logic                resp_valid_i,

  // Prefetch FIFO control
  output logic                     fifo_push_o,
  output logic                     fifo_pop_o,
  output logic                     fifo_flush_o,
  input  wire prefetch_pkg::cnt_t  fifo_cnt_i,
  input  wire logic                fifo_empty_i
);

  // Requests in flight, fed back for capacity gating
  prefetch_pkg::cnt_t outstanding_cnt;
  // Request handshake completed this cycle
  logic               accepted;

  prefetch_addr_fsm u_addr_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req_i),
    .branch_i          (branch_i),
    .branch_addr_i     (branch_addr_i),
    .fifo_cnt_i        (fifo_cnt_i),
    .outstanding_cnt_i (outstanding_cnt),
    .trans_ready_i     (trans_ready_i),
    .trans_valid_o     (trans_valid_o),
    .trans_addr_o      (trans_addr_o),
    .accepted_o        (accepted)
  );

  prefetch_resp_ctrl u_resp_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .branch_i          (branch_i),
    .accepted_i        (accepted),
    .trans_valid_i     (trans_valid_o),
    .resp_valid_i      (resp_valid_i),
    .fetch_ready_i     (fetch_ready_i),
    .fifo_empty_i      (fifo_empty_i),
    .outstanding_cnt_o (outstanding_cnt),
    .fetch_valid_o     (fetch_valid_o),
    .fifo_push_o       (fifo_push_o),
    .fifo_pop_o        (fifo_pop_o),
    .fifo_flush_o      (fifo_flush_o),
    .busy_o            (busy_o)
  );

endmodule

`default_nettype wire

/* logic/prefetch_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Prefetch controller shared definitions
// Holds the FIFO depth, count and address widths, the sequential
// fetch step, and the address and count types used across the design
//////////////////////////////////////////////////////////////////////

`default_nettype none

package prefetch_pkg;

  // Number of prefetch FIFO entries, also the cap on outstanding requests
  localparam int unsigned DEPTH = 4;

  // Wide enough to hold any count from zero up to DEPTH inclusive
  localparam int unsigned CNT_W = $clog2(DEPTH) + 1;

  // Instruction address width
  localparam int unsigned ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // Byte distance between two sequential word fetches
  localparam addr_t ADDR_STEP = addr_t'(4);

endpackage

`default_nettype wire

/* logic/prefetch_resp_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Prefetch response bookkeeping
// Counts outstanding requests, drops responses that belong to
// requests issued before a branch, and steers the surviving ones
// to the fetch stage or into the prefetch FIFO
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_resp_ctrl (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         branch_i,
  input  wire logic         accepted_i,
  input  wire logic         trans_valid_i,
  input  wire logic         resp_valid_i,
  input  wire logic         fetch_ready_i,
  input  wire logic         fifo_empty_i,
  output prefetch_pkg::cnt_t outstanding_cnt_o,
  output logic              fetch_valid_o,
  output logic              fifo_push_o,
  output logic              fifo_pop_o,
  output logic              fifo_flush_o,
  output logic              busy_o
);

  prefetch_pkg::cnt_t outstanding_q;
  prefetch_pkg::cnt_t outstanding_d;
  prefetch_pkg::cnt_t flush_cnt_q;
  prefetch_pkg::cnt_t flush_cnt_d;
  logic               fifo_valid;
  logic               discard;

  //////////////////////////////////////////////////////////////////////
  // Outstanding request counter
  //////////////////////////////////////////////////////////////////////

  // The request gating keeps this at or below DEPTH, and a response
  // only ever follows an accepted request, so it never wraps
  always_comb begin
    case ({accepted_i, resp_valid_i})
      2'b10:   outstanding_d = outstanding_q + prefetch_pkg::cnt_t'(1);
      2'b01:   outstanding_d = outstanding_q - prefetch_pkg::cnt_t'(1);
      default: outstanding_d = outstanding_q;
    endcase
  end

  assign outstanding_cnt_o = outstanding_q;

  //////////////////////////////////////////////////////////////////////
  // Response flush counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      // Every request still in flight at the branch returns a stale word.
      // Words already in the FIFO are dropped by the FIFO flush itself
      flush_cnt_d = outstanding_q;
      // A response landing in the branch cycle is discarded right away
      if (resp_valid_i && (outstanding_q != '0)) begin
        flush_cnt_d = outstanding_q - prefetch_pkg::cnt_t'(1);
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - prefetch_pkg::cnt_t'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fetch and FIFO steering
  //////////////////////////////////////////////////////////////////////

  assign fifo_valid = !fifo_empty_i;

  // Nothing reaches the fetch stage while stale words are still due
  assign discard = branch_i || (flush_cnt_q != '0);

  assign fetch_valid_o = (fifo_valid || resp_valid_i) && !discard;

  // A response bypasses the FIFO only when the FIFO is empty and the
  // fetch stage takes the word in this very cycle, which keeps order
  assign fifo_push_o = resp_valid_i && (fifo_valid || !fetch_ready_i) && !discard;
  assign fifo_pop_o  = fifo_valid && fetch_ready_i;

  // Every buffered word is on the wrong path after a branch
  assign fifo_flush_o = branch_i;

  // Busy while anything is in flight or about to be requested
  assign busy_o = (outstanding_q != '0) || trans_valid_i;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      flush_cnt_q   <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      flush_cnt_q   <= flush_cnt_d;
    end
  end

endmodule

`default_nettype wire

/* tb.f */
logic/prefetch_pkg.sv
logic/prefetch_addr_fsm.sv
logic/prefetch_resp_ctrl.sv
logic/prefetch_ctrl.sv
test/tb_clk_gen.sv
test/tb_prefetch_ctrl.sv

/* test/tb_clk_gen.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock source
// Free-running clock that starts low and toggles every half period
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period high, half period low
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* test/tb_prefetch_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Prefetch controller testbench
// Drives random fetch, branch and bus traffic, models the bus and the
// prefetch FIFO, and checks every DUT output against reference
// counters built from the controller rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_ctrl;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 2;
  localparam int NUM_CYCLES   = 3000;
  // Reset, the idle check and some slack on top of the stimulus length
  localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;
  localparam int DEPTH        = int'(prefetch_pkg::DEPTH);

  logic                clk;
  logic                rst_n;
  logic                req_i;
  logic                branch_i;
  prefetch_pkg::addr_t branch_addr_i;
  logic                fetch_ready_i;
  logic                fetch_valid_o;
  logic                busy_o;
  logic                trans_valid_o;
  prefetch_pkg::addr_t trans_addr_o;
  logic                trans_ready_i;
  logic                resp_valid_i;
  logic                fifo_push_o;
  logic                fifo_pop_o;
  logic                fifo_flush_o;
  prefetch_pkg::cnt_t  fifo_cnt_i;
  logic                fifo_empty_i;

  // Reference state, updated once per cycle after the checks
  int                  model_out;
  int                  model_flush;
  int                  model_fifo;
  logic                model_wait;
  prefetch_pkg::addr_t model_addr;
  // Cycle numbers at which the bus answers, oldest request first
  int                  resp_due[$];
  int                  last_due;
  int                  cyc;

  // Expected values of the current cycle, shared with the model update
  logic                exp_valid;
  logic                exp_accept;
  prefetch_pkg::addr_t exp_addr;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.clk_o(clk));

  prefetch_ctrl dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .busy_o        (busy_o),
    .trans_valid_o (trans_valid_o),
    .trans_addr_o  (trans_addr_o),
    .trans_ready_i (trans_ready_i),
    .resp_valid_i  (resp_valid_i),
    .fifo_push_o   (fifo_push_o),
    .fifo_pop_o    (fifo_pop_o),
    .fifo_flush_o  (fifo_flush_o),
    .fifo_cnt_i    (fifo_cnt_i),
    .fifo_empty_i  (fifo_empty_i)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "Output mismatch on %s", name);
  endtask

  task automatic report_error(input string what);
    $display("Error: %s", what);
    $display("TEST FAILED");
    $fatal(1, "%s", what);
  endtask

  // The DUT never has more requests in flight than the FIFO can hold
  outstanding_bounded: assert property (
    @(posedge clk) disable iff (!rst_n)
    dut.outstanding_cnt <= prefetch_pkg::cnt_t'(DEPTH)
  ) else report_error("outstanding requests exceed the FIFO depth");

  //////////////////////////////////////////////////////////////////////
  // Stimulus, checks and reference models
  //////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    req_i    = ($urandom_range(0, 99) < 85);
    branch_i = ($urandom_range(0, 11) == 0);
    if (branch_i) begin
      branch_addr_i      = $urandom();
      // Misaligned targets exercise the word alignment
      branch_addr_i[1:0] = 2'($urandom_range(1, 3));
    end
    trans_ready_i = ($urandom_range(0, 9) < 7);
    fetch_ready_i = ($urandom_range(0, 3) != 0);
    // Bus model answers in order once a response is due
    resp_valid_i  = (resp_due.size() != 0) && (resp_due[0] <= cyc);
    fifo_cnt_i    = prefetch_pkg::cnt_t'(model_fifo);
    fifo_empty_i  = (model_fifo == 0);
  endtask

  task automatic check_idle_outputs();
    assert (!trans_valid_o) else report_mismatch("trans_valid_o", 32'(trans_valid_o), 0);
    assert (!fetch_valid_o) else report_mismatch("fetch_valid_o", 32'(fetch_valid_o), 0);
    assert (!fifo_push_o) else report_mismatch("fifo_push_o", 32'(fifo_push_o), 0);
    assert (!fifo_pop_o) else report_mismatch("fifo_pop_o", 32'(fifo_pop_o), 0);
    assert (!fifo_flush_o) else report_mismatch("fifo_flush_o", 32'(fifo_flush_o), 0);
    assert (!busy_o) else report_mismatch("busy_o", 32'(busy_o), 0);
  endtask

  task automatic check_outputs();
    int   fifo_eff;
    logic fifo_has;
    logic discard;
    logic exp_fetch_valid;
    logic exp_push;
    logic exp_pop;
    logic exp_busy;
    // The FIFO is flushed on a branch so its entries free up at once
    fifo_eff   = branch_i ? 0 : model_fifo;
    exp_valid  = req_i && (fifo_eff + model_out < DEPTH);
    exp_accept = exp_valid && trans_ready_i;
    if (branch_i) begin
      exp_addr = {branch_addr_i[31:2], 2'b00};
    end else if (model_wait) begin
      exp_addr = model_addr;
    end else begin
      exp_addr = {model_addr[31:2], 2'b00} + prefetch_pkg::ADDR_STEP;
    end
    fifo_has        = (model_fifo != 0);
    discard         = branch_i || (model_flush != 0);
    exp_fetch_valid = (fifo_has || resp_valid_i) && !discard;
    exp_push        = resp_valid_i && !discard && (fifo_has || !fetch_ready_i);
    exp_pop         = fifo_has && fetch_ready_i;
    exp_busy        = (model_out != 0) || exp_valid;

    assert (trans_valid_o == exp_valid)
      else report_mismatch("trans_valid_o", 32'(trans_valid_o), 32'(exp_valid));
    if (exp_valid || branch_i) begin
      assert (trans_addr_o == exp_addr)
        else report_mismatch("trans_addr_o", trans_addr_o, exp_addr);
    end
    assert (fifo_flush_o == branch_i)
      else report_mismatch("fifo_flush_o", 32'(fifo_flush_o), 32'(branch_i));
    assert (fetch_valid_o == exp_fetch_valid)
      else report_mismatch("fetch_valid_o", 32'(fetch_valid_o), 32'(exp_fetch_valid));
    assert (fifo_push_o == exp_push)
      else report_mismatch("fifo_push_o", 32'(fifo_push_o), 32'(exp_push));
    assert (fifo_pop_o == exp_pop)
      else report_mismatch("fifo_pop_o", 32'(fifo_pop_o), 32'(exp_pop));
    assert (busy_o == exp_busy)
      else report_mismatch("busy_o", 32'(busy_o), 32'(exp_busy));
  endtask

  task automatic update_models();
    int due;
    if (branch_i) begin
      // Words still in flight at the branch come back stale
      model_flush = model_out - (resp_valid_i ? 1 : 0);
      model_fifo  = 0;
    end else begin
      if (resp_valid_i && (model_flush != 0)) begin
        model_flush = model_flush - 1;
      end
      model_fifo = model_fifo + (fifo_push_o ? 1 : 0) - (fifo_pop_o ? 1 : 0);
    end
    model_out = model_out + (exp_accept ? 1 : 0) - (resp_valid_i ? 1 : 0);
    if (branch_i || exp_accept) begin
      model_addr = exp_addr;
    end
    model_wait = branch_i ? !exp_accept : (model_wait && !exp_accept);
    if (resp_valid_i) begin
      void'(resp_due.pop_front());
    end
    if (exp_accept) begin
      due = cyc + int'($urandom_range(1, 4));
      // Keep responses in order, one per cycle at most
      if (due <= last_due) begin
        due = last_due + 1;
      end
      resp_due.push_back(due);
      last_due = due;
    end
  endtask

  initial begin
    void'($urandom(32'h502b72e8));
    rst_n         = 1'b0;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    trans_ready_i = 1'b0;
    resp_valid_i  = 1'b0;
    fifo_cnt_i    = '0;
    fifo_empty_i  = 1'b1;
    model_out     = 0;
    model_flush   = 0;
    model_fifo    = 0;
    model_wait    = 1'b0;
    model_addr    = '0;
    last_due      = 0;
    cyc           = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    // First cycle out of reset with all requests idle
    @(negedge clk);
    check_idle_outputs();

    for (int i = 0; i < NUM_CYCLES; i++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      cyc = cyc + 1;
      drive_inputs();
      // Outputs are settled halfway through the cycle
      @(negedge clk);
      check_outputs();
      update_models();
    end

    $display("TEST OK");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Error: simulation did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $fatal(1, "Watchdog timeout");
  end

endmodule

`default_nettype wire
